// File: router_pkg.sv
// router_pkg holds the shared types and constants of the mesh tile router
package router_pkg;

    // ==================================================
    // sizes
    // ==================================================
    localparam int NUM_PORTS    = 5;   // N E S W local
    localparam int TILE_COORD_W = 4;   // per axis
    localparam int OFFSET_W     = 24;  // address below the tile byte
    localparam int DATA_W       = 32;

    // tile coordinate, x in the upper nibble
    typedef struct packed {
        logic [TILE_COORD_W-1:0] x;
        logic [TILE_COORD_W-1:0] y;
    } t_tile_id;

    // port index, also the arbiter id
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_cardinal;

    typedef enum logic [1:0] {
        RD     = 2'd0,
        WR     = 2'd1,
        RD_RSP = 2'd2,
        WR_RSP = 2'd3
    } t_opcode;

    // ==================================================
    // address and transaction
    // ==================================================
    typedef struct packed {
        t_tile_id              dest_tile;  // top byte picks the tile
        logic [OFFSET_W-1:0]   offset;
    } t_addr_fields;

    // same 32 bits seen raw or split
    typedef union packed {
        logic [DATA_W-1:0] raw;
        t_addr_fields      fields;
    } t_addr;

    typedef struct packed {
        t_opcode           opcode;
        t_addr             address;
        logic [DATA_W-1:0] data;
        t_cardinal         next_tile_fifo_arb_id;  // exit port, filled by the decoder
    } t_tile_trans;

    typedef logic [NUM_PORTS-1:0] t_port_mask;  // bit per t_cardinal

endpackage

// File: fab_link_if.sv
// fab_link_if is the valid/ready link that carries one tile transaction per transfer
`timescale 1ns/1ps

interface fab_link_if;

    logic                    valid;  // req is meaningful
    logic                    ready;  // receiver can take it
    router_pkg::t_tile_trans req;

    // upstream side
    modport sender (
        output valid,
        output req,
        input  ready
    );

    // downstream side
    modport receiver (
        input  valid,
        input  req,
        output ready
    );

endinterface

// File: route_decode.sv
// route_decode buffers one incoming transaction and picks its XY exit port
`timescale 1ns/1ps

module route_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  router_pkg::t_tile_id          local_tile_id,
    fab_link_if.receiver                  in_link,
    input  logic                          grant,       // OR of all arbiter grants for us
    output logic                          pend_valid,
    output router_pkg::t_tile_trans       pend_req,
    output router_pkg::t_cardinal         pend_card
);

    logic                    buf_valid;
    router_pkg::t_tile_trans buf_req;    // payload, no reset
    router_pkg::t_tile_id    dest;
    router_pkg::t_cardinal   card_d;     // decoded exit for the incoming req

    // ==================================================
    // XY decode on the incoming transaction
    // ==================================================
    assign dest = in_link.req.address.fields.dest_tile;

    always_comb begin
        // x first
        if (dest.x > local_tile_id.x) begin
            card_d = router_pkg::EAST;
        end else if (dest.x < local_tile_id.x) begin
            card_d = router_pkg::WEST;
        // then y, south grows y
        end else if (dest.y > local_tile_id.y) begin
            card_d = router_pkg::SOUTH;
        end else if (dest.y < local_tile_id.y) begin
            card_d = router_pkg::NORTH;
        end else begin
            card_d = router_pkg::LOCAL;  // arrived
        end
    end

    // ==================================================
    // one entry buffer
    // ==================================================
    // take a new one when empty or when the current one leaves this cycle
    assign in_link.ready = !buf_valid || grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (in_link.valid && in_link.ready) begin
            buf_valid <= 1'b1;
        end else if (grant) begin
            buf_valid <= 1'b0;  // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (in_link.valid && in_link.ready) begin
            buf_req                       <= in_link.req;
            buf_req.next_tile_fifo_arb_id <= card_d;  // stamp exit port
        end
    end

    assign pend_valid = buf_valid;
    assign pend_req   = buf_req;
    assign pend_card  = buf_req.next_tile_fifo_arb_id;

endmodule

// File: out_port_arb.sv
// out_port_arb picks one input round robin for its output port and forwards that transaction
`timescale 1ns/1ps

module out_port_arb (
    input  logic                    clk,
    input  logic                    reset,
    input  router_pkg::t_cardinal   port_id,                                  // tied per instance
    input  router_pkg::t_port_mask  req_valid,
    input  router_pkg::t_cardinal   req_card [router_pkg::NUM_PORTS],
    input  var router_pkg::t_tile_trans req_data [router_pkg::NUM_PORTS],
    output router_pkg::t_port_mask  grant,
    fab_link_if.sender              out_link
);

    router_pkg::t_port_mask req_mask;    // inputs heading to this port
    router_pkg::t_cardinal  rr_ptr;      // highest priority next round
    router_pkg::t_cardinal  rr_idx;
    logic                   rr_found;
    logic                   lock_valid;  // stalled last cycle, keep same winner
    router_pkg::t_cardinal  lock_idx;
    router_pkg::t_cardinal  win_idx;
    logic                   xfer;

    // ==================================================
    // requests and round robin pick
    // ==================================================
    always_comb begin
        for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
            req_mask[i] = req_valid[i] && (req_card[i] == port_id);
        end
    end

    always_comb begin : rr_pick
        int cand;
        rr_found = 1'b0;
        rr_idx   = router_pkg::NORTH;
        // walk from the pointer, first requester wins
        for (int i = 0; i < router_pkg::NUM_PORTS; i++) begin
            cand = int'(rr_ptr) + i;
            if (cand >= router_pkg::NUM_PORTS) begin
                cand = cand - router_pkg::NUM_PORTS;  // wrap
            end
            if (!rr_found && req_mask[cand]) begin
                rr_found = 1'b1;
                rr_idx   = router_pkg::t_cardinal'(cand);
            end
        end
    end

    // held winner keeps req stable while the register is full
    assign win_idx = lock_valid ? lock_idx : rr_idx;

    assign out_link.valid = |req_mask;
    assign out_link.req   = req_data[win_idx];
    assign xfer           = out_link.valid && out_link.ready;

    always_comb begin
        grant = '0;
        if (xfer) begin
            grant[win_idx] = 1'b1;  // one hot, back to the decoder
        end
    end

    // ==================================================
    // pointer and stall lock
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr     <= router_pkg::NORTH;
            lock_valid <= 1'b0;
        end else begin
            lock_valid <= out_link.valid && !out_link.ready;
            if (xfer) begin
                // start after the last winner
                rr_ptr <= (win_idx == router_pkg::LOCAL) ? router_pkg::NORTH
                                                         : router_pkg::t_cardinal'(win_idx + 3'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        lock_idx <= win_idx;  // only looked at when lock_valid
    end

endmodule

// File: out_port_reg.sv
// out_port_reg is the one entry output register that drives an outgoing link
`timescale 1ns/1ps

module out_port_reg (
    input  logic          clk,
    input  logic          reset,
    fab_link_if.receiver  in_link,   // from the arbiter
    fab_link_if.sender    out_link   // to the next tile
);

    logic                    full;
    router_pkg::t_tile_trans data_q;

    // refill in the same cycle the entry drains, no bubble
    assign in_link.ready = !full || out_link.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (in_link.ready) begin
            full <= in_link.valid;  // load, drain or both
        end
    end

    always_ff @(posedge clk) begin
        if (in_link.valid && in_link.ready) begin
            data_q <= in_link.req;
        end
    end

    // held steady while the far side stalls
    assign out_link.valid = full;
    assign out_link.req   = data_q;

endmodule

// File: router.sv
// router is the five port crossbar with per input decode and per output arbitration
`timescale 1ns/1ps

module router (
    input  logic                  clk,
    input  logic                  reset,
    input  router_pkg::t_tile_id  local_tile_id,
    fab_link_if.receiver          in_links  [router_pkg::NUM_PORTS],  // indexed by t_cardinal
    fab_link_if.sender            out_links [router_pkg::NUM_PORTS]
);

    router_pkg::t_port_mask  pend_valid;
    router_pkg::t_tile_trans pend_req  [router_pkg::NUM_PORTS];
    router_pkg::t_cardinal   pend_card [router_pkg::NUM_PORTS];
    router_pkg::t_port_mask  arb_grant [router_pkg::NUM_PORTS];  // per arbiter, bit per input
    router_pkg::t_port_mask  dec_grant;                          // per input

    fab_link_if arb_to_reg [router_pkg::NUM_PORTS] ();

    // ==================================================
    // grant transpose
    // ==================================================
    // at most one arbiter grants a given input
    always_comb begin
        dec_grant = '0;
        for (int a = 0; a < router_pkg::NUM_PORTS; a++) begin
            dec_grant = dec_grant | arb_grant[a];
        end
    end

    for (genvar p = 0; p < router_pkg::NUM_PORTS; p++) begin : g_port
        // input side
        route_decode u_dec (
            .clk           (clk),
            .reset         (reset),
            .local_tile_id (local_tile_id),
            .in_link       (in_links[p]),
            .grant         (dec_grant[p]),
            .pend_valid    (pend_valid[p]),
            .pend_req      (pend_req[p]),
            .pend_card     (pend_card[p])
        );

        // output side, sees every input
        out_port_arb u_arb (
            .clk       (clk),
            .reset     (reset),
            .port_id   (router_pkg::t_cardinal'(p)),
            .req_valid (pend_valid),
            .req_card  (pend_card),
            .req_data  (pend_req),
            .grant     (arb_grant[p]),
            .out_link  (arb_to_reg[p])
        );

        out_port_reg u_reg (
            .clk      (clk),
            .reset    (reset),
            .in_link  (arb_to_reg[p]),
            .out_link (out_links[p])
        );
    end

endmodule

// File: mini_core_tile.sv
// mini_core_tile is the tile top that exposes the router links as plain ports
`timescale 1ns/1ps

module mini_core_tile (
    input  logic                        clk,
    input  logic                        reset,
    input  router_pkg::t_tile_id        local_tile_id,
    // ==================================================
    // north, east, south, west, local
    // ==================================================
    input  logic                        in_north_req_valid,
    input  var router_pkg::t_tile_trans in_north_req,
    output logic                        out_north_ready,
    output logic                        out_north_req_valid,
    output router_pkg::t_tile_trans     out_north_req,
    input  logic                        in_north_ready,
    input  logic                        in_east_req_valid,
    input  var router_pkg::t_tile_trans in_east_req,
    output logic                        out_east_ready,
    output logic                        out_east_req_valid,
    output router_pkg::t_tile_trans     out_east_req,
    input  logic                        in_east_ready,
    input  logic                        in_south_req_valid,
    input  var router_pkg::t_tile_trans in_south_req,
    output logic                        out_south_ready,
    output logic                        out_south_req_valid,
    output router_pkg::t_tile_trans     out_south_req,
    input  logic                        in_south_ready,
    input  logic                        in_west_req_valid,
    input  var router_pkg::t_tile_trans in_west_req,
    output logic                        out_west_ready,
    output logic                        out_west_req_valid,
    output router_pkg::t_tile_trans     out_west_req,
    input  logic                        in_west_ready,
    // local core link, driven from outside for now
    input  logic                        in_local_req_valid,
    input  var router_pkg::t_tile_trans in_local_req,
    output logic                        out_local_ready,
    output logic                        out_local_req_valid,
    output router_pkg::t_tile_trans     out_local_req,
    input  logic                        in_local_ready
);

    fab_link_if in_if  [router_pkg::NUM_PORTS] ();  // into the router
    fab_link_if out_if [router_pkg::NUM_PORTS] ();  // out of the router

    router router_inst (
        .clk           (clk),
        .reset         (reset),
        .local_tile_id (local_tile_id),
        .in_links      (in_if),
        .out_links     (out_if)
    );

    // ==================================================
    // port mapping
    // ==================================================
    assign in_if[router_pkg::NORTH].valid  = in_north_req_valid;
    assign in_if[router_pkg::NORTH].req    = in_north_req;
    assign out_north_ready                 = in_if[router_pkg::NORTH].ready;
    assign out_north_req_valid             = out_if[router_pkg::NORTH].valid;
    assign out_north_req                   = out_if[router_pkg::NORTH].req;
    assign out_if[router_pkg::NORTH].ready = in_north_ready;

    assign in_if[router_pkg::EAST].valid   = in_east_req_valid;
    assign in_if[router_pkg::EAST].req     = in_east_req;
    assign out_east_ready                  = in_if[router_pkg::EAST].ready;
    assign out_east_req_valid              = out_if[router_pkg::EAST].valid;
    assign out_east_req                    = out_if[router_pkg::EAST].req;
    assign out_if[router_pkg::EAST].ready  = in_east_ready;

    assign in_if[router_pkg::SOUTH].valid  = in_south_req_valid;
    assign in_if[router_pkg::SOUTH].req    = in_south_req;
    assign out_south_ready                 = in_if[router_pkg::SOUTH].ready;
    assign out_south_req_valid             = out_if[router_pkg::SOUTH].valid;
    assign out_south_req                   = out_if[router_pkg::SOUTH].req;
    assign out_if[router_pkg::SOUTH].ready = in_south_ready;

    assign in_if[router_pkg::WEST].valid   = in_west_req_valid;
    assign in_if[router_pkg::WEST].req     = in_west_req;
    assign out_west_ready                  = in_if[router_pkg::WEST].ready;
    assign out_west_req_valid              = out_if[router_pkg::WEST].valid;
    assign out_west_req                    = out_if[router_pkg::WEST].req;
    assign out_if[router_pkg::WEST].ready  = in_west_ready;

    // core side of the local port
    assign in_if[router_pkg::LOCAL].valid  = in_local_req_valid;
    assign in_if[router_pkg::LOCAL].req    = in_local_req;
    assign out_local_ready                 = in_if[router_pkg::LOCAL].ready;
    assign out_local_req_valid             = out_if[router_pkg::LOCAL].valid;
    assign out_local_req                   = out_if[router_pkg::LOCAL].req;
    assign out_if[router_pkg::LOCAL].ready = in_local_ready;

endmodule

// File: tile_tb_tasks.svh
// tile_tb_tasks holds the stimulus, scoreboard and compare tasks of the tile testbench

    // ==================================================
    // routing rule and transaction build
    // ==================================================
    // XY exit port seen from this tile, x first then y
    function automatic router_pkg::t_cardinal xy_exit(input router_pkg::t_tile_id d);
        if (d.x > local_id.x) return router_pkg::EAST;
        if (d.x < local_id.x) return router_pkg::WEST;
        if (d.y > local_id.y) return router_pkg::SOUTH;  // y grows southward
        if (d.y < local_id.y) return router_pkg::NORTH;
        return router_pkg::LOCAL;
    endfunction

    function automatic string port_name(input int p);
        router_pkg::t_cardinal c;
        string s;
        c = router_pkg::t_cardinal'(p);
        s = c.name();
        return s.tolower();
    endfunction

    // data carries the source port and a running tag
    function automatic router_pkg::t_tile_trans make_trans(input int src, input logic [7:0] dest,
                                                           input logic [31:0] rnd);
        router_pkg::t_tile_trans t;
        t.opcode                = router_pkg::t_opcode'(rnd[25:24]);
        t.address.raw           = {dest, rnd[23:0]};
        t.data                  = {src[3:0], seq[27:0]};
        t.next_tile_fifo_arb_id = router_pkg::NORTH;  // overwritten in the router
        seq++;
        return t;
    endfunction

    // ==================================================
    // compares
    // ==================================================
    task automatic check_trans(input string name, input router_pkg::t_tile_trans exp,
                               input router_pkg::t_tile_trans act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_card(input string name, input router_pkg::t_cardinal exp,
                              input router_pkg::t_cardinal act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    // ==================================================
    // drive and wait
    // ==================================================
    // called just after a rising edge, returns just after the transfer edge
    task automatic send_trans(input int port, input router_pkg::t_tile_trans t);
        router_pkg::t_tile_trans exp;
        int n;
        exp                       = t;
        exp.next_tile_fifo_arb_id = xy_exit(t.address.fields.dest_tile);
        src_valid[port]           = 1'b1;
        src_req[port]             = t;
        @(negedge clk);
        for (n = 0; n < 200 && !src_ready[port]; n++) begin
            @(negedge clk);
        end
        if (src_ready[port]) begin
            exp_q[port][exp.next_tile_fifo_arb_id].push_back(exp);  // accepted next edge
        end else begin
            $display("timeout at %0t, input %s never took its transaction", $time,
                     port_name(port));
            err_count++;
        end
        @(posedge clk);
        #1;
        src_valid[port] = 1'b0;
    endtask

    // dest below zero picks a random tile per transaction
    task automatic drive_stream(input int port, input int count, input int dest);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $urandom();
            send_trans(port, make_trans(port, (dest < 0) ? r[7:0] : 8'(dest), r));
        end
    endtask

    // every accepted transaction has to leave, bounded
    task automatic wait_drain();
        int left;
        left = 0;
        for (int n = 0; n < 500; n++) begin
            left = 0;
            for (int s = 0; s < router_pkg::NUM_PORTS; s++) begin
                for (int d = 0; d < router_pkg::NUM_PORTS; d++) begin
                    left += exp_q[s][d].size();
                end
            end
            if (left == 0) begin
                break;
            end
            @(posedge clk);
        end
        if (left != 0) begin
            $display("timeout at %0t, %0d transactions never left the tile", $time, left);
            err_count++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, err_count - errs_before);
            fail_tests++;
        end
    endtask

// File: tile_tb.sv
// tile_tb drives the mesh tile on all five links and scores every transaction that leaves
`timescale 1ns/1ps

module tile_tb;

    logic                    clk;
    logic                    reset;
    router_pkg::t_tile_id    local_id;
    logic                    src_valid [router_pkg::NUM_PORTS];  // into the tile
    router_pkg::t_tile_trans src_req   [router_pkg::NUM_PORTS];
    logic                    src_ready [router_pkg::NUM_PORTS];
    logic                    dst_valid [router_pkg::NUM_PORTS];  // out of the tile
    router_pkg::t_tile_trans dst_req   [router_pkg::NUM_PORTS];
    logic                    dst_ready [router_pkg::NUM_PORTS];

    router_pkg::t_tile_trans exp_q [router_pkg::NUM_PORTS][router_pkg::NUM_PORTS][$];
    int east_src [$];  // source of each east output, in order
    int err_count;
    int test_count;
    int fail_tests;
    int seq;

    `include "tile_tb_tasks.svh"

    mini_core_tile DUT (
        .clk                 (clk),
        .reset               (reset),
        .local_tile_id       (local_id),
        .in_north_req_valid  (src_valid[router_pkg::NORTH]),
        .in_north_req        (src_req[router_pkg::NORTH]),
        .out_north_ready     (src_ready[router_pkg::NORTH]),
        .out_north_req_valid (dst_valid[router_pkg::NORTH]),
        .out_north_req       (dst_req[router_pkg::NORTH]),
        .in_north_ready      (dst_ready[router_pkg::NORTH]),
        .in_east_req_valid   (src_valid[router_pkg::EAST]),
        .in_east_req         (src_req[router_pkg::EAST]),
        .out_east_ready      (src_ready[router_pkg::EAST]),
        .out_east_req_valid  (dst_valid[router_pkg::EAST]),
        .out_east_req        (dst_req[router_pkg::EAST]),
        .in_east_ready       (dst_ready[router_pkg::EAST]),
        .in_south_req_valid  (src_valid[router_pkg::SOUTH]),
        .in_south_req        (src_req[router_pkg::SOUTH]),
        .out_south_ready     (src_ready[router_pkg::SOUTH]),
        .out_south_req_valid (dst_valid[router_pkg::SOUTH]),
        .out_south_req       (dst_req[router_pkg::SOUTH]),
        .in_south_ready      (dst_ready[router_pkg::SOUTH]),
        .in_west_req_valid   (src_valid[router_pkg::WEST]),
        .in_west_req         (src_req[router_pkg::WEST]),
        .out_west_ready      (src_ready[router_pkg::WEST]),
        .out_west_req_valid  (dst_valid[router_pkg::WEST]),
        .out_west_req        (dst_req[router_pkg::WEST]),
        .in_west_ready       (dst_ready[router_pkg::WEST]),
        .in_local_req_valid  (src_valid[router_pkg::LOCAL]),
        .in_local_req        (src_req[router_pkg::LOCAL]),
        .out_local_ready     (src_ready[router_pkg::LOCAL]),
        .out_local_req_valid (dst_valid[router_pkg::LOCAL]),
        .out_local_req       (dst_req[router_pkg::LOCAL]),
        .in_local_ready      (dst_ready[router_pkg::LOCAL])
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ==================================================
    // scoreboard, a transfer seen here completes at the next rising edge
    // ==================================================
    always @(negedge clk) begin : monitor
        int src;
        for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
            if (!reset && dst_valid[p] && dst_ready[p]) begin
                src = int'(dst_req[p].data[31:28]);  // source tag
                if (p == int'(router_pkg::EAST)) begin
                    east_src.push_back(src);
                end
                if (src >= router_pkg::NUM_PORTS || exp_q[src][p].size() == 0) begin
                    $display("unexpected transaction on output %s at %0t", port_name(p), $time);
                    err_count++;
                end else begin
                    check_trans({"out_", port_name(p), "_req"}, exp_q[src][p].pop_front(),
                                dst_req[p]);
                    check_card("next_tile_fifo_arb_id", router_pkg::t_cardinal'(p),
                               dst_req[p].next_tile_fifo_arb_id);
                end
            end
        end
    end

    // ==================================================
    // tests
    // ==================================================
    task automatic reset_values();
        int e;
        e = err_count;
        for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
            check_bit({"out_", port_name(p), "_req_valid"}, 1'b0, dst_valid[p]);
            check_bit({"out_", port_name(p), "_ready"}, 1'b1, src_ready[p]);
        end
        report_test("reset", e);
    endtask

    // one destination per exit, the last two hit local and a far east tile
    task automatic local_routing();
        logic [7:0] dests [6] = '{8'h64, 8'h17, 8'h49, 8'h42, 8'h44, 8'h90};
        int e;
        e = err_count;
        for (int i = 0; i < 6; i++) begin
            send_trans(router_pkg::LOCAL, make_trans(router_pkg::LOCAL, dests[i], $urandom()));
        end
        wait_drain();
        report_test("local routing", e);
    endtask

    task automatic pass_through();
        int e;
        e = err_count;
        send_trans(router_pkg::NORTH, make_trans(router_pkg::NORTH, 8'h64, $urandom()));
        @(negedge clk);  // one cycle after the transfer, still in the decoder
        check_bit("out_east_req_valid", 1'b0, dst_valid[router_pkg::EAST]);
        @(negedge clk);
        check_bit("out_east_req_valid", 1'b1, dst_valid[router_pkg::EAST]);
        wait_drain();
        report_test("pass through", e);
    endtask

    task automatic back_pressure();
        router_pkg::t_tile_trans held;
        int e;
        e = err_count;
        dst_ready[router_pkg::SOUTH] = 1'b0;
        // first fills the output register, second the north buffer
        held = make_trans(router_pkg::NORTH, 8'h46, $urandom());
        send_trans(router_pkg::NORTH, held);
        send_trans(router_pkg::NORTH, make_trans(router_pkg::NORTH, 8'h47, $urandom()));
        held.next_tile_fifo_arb_id = router_pkg::SOUTH;  // y 6 lies south of y 4
        for (int i = 0; i < 7; i++) begin
            @(negedge clk);
            check_trans("out_south_req", held, dst_req[router_pkg::SOUTH]);
        end
        check_bit("out_south_req_valid", 1'b1, dst_valid[router_pkg::SOUTH]);
        check_bit("out_north_ready", 1'b0, src_ready[router_pkg::NORTH]);
        @(posedge clk);
        #1;
        dst_ready[router_pkg::SOUTH] = 1'b1;
        send_trans(router_pkg::NORTH, make_trans(router_pkg::NORTH, 8'h4f, $urandom()));
        wait_drain();
        report_test("back pressure", e);
    endtask

    // three saturated streams, round robin gives each at most two others between its grants
    task automatic contention();
        int last [16];
        int gap;
        int e;
        e = err_count;
        east_src.delete();
        fork
            drive_stream(router_pkg::NORTH, 6, 8'h74);
            drive_stream(router_pkg::WEST, 6, 8'ha2);
            drive_stream(router_pkg::LOCAL, 6, 8'h5f);
        join
        wait_drain();
        for (int s = 0; s < 16; s++) begin
            last[s] = -1;
        end
        for (int i = 0; i < east_src.size(); i++) begin
            gap = i - last[east_src[i]] - 1;
            if (gap > 2) begin
                $display("input %0d waited for %0d grants to other inputs", east_src[i], gap);
                err_count++;
            end
            last[east_src[i]] = i;
        end
        report_test("contention", e);
    endtask

    task automatic random_traffic();
        logic jitter_on;
        int e;
        e = err_count;
        jitter_on = 1'b1;
        fork
            begin
                fork
                    drive_stream(router_pkg::NORTH, 40, -1);
                    drive_stream(router_pkg::EAST, 40, -1);
                    drive_stream(router_pkg::SOUTH, 40, -1);
                    drive_stream(router_pkg::WEST, 40, -1);
                    drive_stream(router_pkg::LOCAL, 40, -1);
                join
                jitter_on = 1'b0;
            end
            while (jitter_on) begin
                @(posedge clk);
                #1;
                for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
                    dst_ready[p] = ($urandom() % 4) != 0;  // ready three cycles in four
                end
            end
        join
        for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
            dst_ready[p] = 1'b1;
        end
        wait_drain();
        report_test("random traffic", e);
    endtask

    // ==================================================
    // sequence
    // ==================================================
    initial begin
        void'($urandom(43014));
        err_count  = 0;
        test_count = 0;
        fail_tests = 0;
        seq        = 0;
        reset      = 1'b1;
        local_id   = '{x: 4'd4, y: 4'd4};
        for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
            src_valid[p] = 1'b0;
            src_req[p]   = '0;
            dst_ready[p] = 1'b1;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_values();
        local_routing();
        pass_through();
        back_pressure();
        contention();
        random_traffic();
        $display("%0d tests run, %0d failed, %0d errors", test_count, fail_tests, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
router_pkg.sv
fab_link_if.sv
route_decode.sv
out_port_arb.sv
out_port_reg.sv
router.sv
mini_core_tile.sv
tile_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the tile testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tile_tb -o tile_tb_sim > build.log 2>&1 \
    && ./obj_dir/tile_tb_sim > sim.log 2>&1 \
    ; cat build.log sim.log 2> /dev/null \
    ; grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
